// ==== design/cache_cfg_pkg.sv ====
`default_nettype none

package cache_cfg_pkg;

	// Line address width in bits
	localparam int ADDR_W = 32;

	// Width of one fill beat
	localparam int LINE_W = 64;

	localparam int FIFO_DEPTH = 8;  // Entries in the fill FIFO
	localparam int LEVEL_W    = 4;  // Holds every level from 0 up to FIFO_DEPTH

	// Almost-full point after reset, leaving two slots of slack
	localparam int AFULL_DEFAULT = FIFO_DEPTH - 2;

	// Configuration register map
	localparam logic REG_THRESH = 1'b0;  // Almost-full threshold, read and write
	localparam logic REG_LEVEL  = 1'b1;  // Live FIFO level, read only

endpackage

`default_nettype wire

// ==== design/fill_types_pkg.sv ====
`default_nettype none

package fill_types_pkg;

	import cache_cfg_pkg::*;

	typedef logic [ADDR_W-1:0]  fill_addr_t;
	typedef logic [LINE_W-1:0]  fill_line_t;
	typedef logic [LEVEL_W-1:0] fifo_level_t;  // Shared by the level and the threshold

	// One fill as it travels from a source to the data array
	typedef struct packed {
		fill_addr_t addr;
		fill_line_t data;
	} fill_entry_t;

	// Single-cycle request on the configuration port
	typedef struct packed {
		logic        wr_en;
		logic        rd_en;
		logic        addr;   // Selects REG_THRESH or REG_LEVEL
		fifo_level_t wdata;
	} cfg_req_t;

	typedef enum logic {
		ARB_IDLE = 1'b0,  // Free to accept a new fill
		ARB_HOLD = 1'b1   // Holding an accepted fill for the FIFO
	} arb_state_e;

endpackage

`default_nettype wire

// ==== design/fill_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module fill_arbiter (
	input  wire logic                        clk,
	input  wire logic                        rst_n,

	input  wire logic                        fill_valid_i,
	input  wire fill_types_pkg::fill_entry_t fill_entry_i,
	output logic                             fill_ready_o,

	input  wire logic                        rmiss_valid_i,
	input  wire fill_types_pkg::fill_entry_t rmiss_entry_i,
	output logic                             rmiss_ready_o,

	input  wire logic                        fifo_afull_i,
	output logic                             fifo_wr_o,
	output fill_types_pkg::fill_entry_t      fifo_wdata_o
);

	import fill_types_pkg::*;

	arb_state_e  state_q;
	arb_state_e  state_d;
	logic        prio_rmiss_q;  // Set when the miss handler wins the next tie
	fill_entry_t entry_q;
	logic        grant_fill;
	logic        grant_rmiss;
	logic        accept;

	// A grant is the ready itself, so the transfer happens in this cycle
	always_comb begin
		grant_fill  = 1'b0;
		grant_rmiss = 1'b0;
		if (state_q == ARB_IDLE && !fifo_afull_i) begin
			grant_fill  = fill_valid_i && (!rmiss_valid_i || !prio_rmiss_q);
			grant_rmiss = rmiss_valid_i && (!fill_valid_i || prio_rmiss_q);
		end
	end

	assign accept        = grant_fill || grant_rmiss;
	assign fill_ready_o  = grant_fill;
	assign rmiss_ready_o = grant_rmiss;

	assign fifo_wr_o    = (state_q == ARB_HOLD) && !fifo_afull_i;  // Waits out back-pressure
	assign fifo_wdata_o = entry_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (accept) begin
					state_d = ARB_HOLD;
				end
			end
			ARB_HOLD: begin
				if (!fifo_afull_i) begin
					state_d = ARB_IDLE;
				end
			end
			default: begin
				state_d = ARB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q      <= ARB_IDLE;
			prio_rmiss_q <= 1'b0;  // Fill source goes first out of reset
		end else begin
			state_q <= state_d;
			if (accept) begin
				prio_rmiss_q <= grant_fill;  // The loser of this round wins the next tie
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant_fill) begin
			entry_q <= fill_entry_i;
		end else if (grant_rmiss) begin
			entry_q <= rmiss_entry_i;
		end
	end

	a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!(fill_ready_o && rmiss_ready_o));

	// A source keeps its offer up and unchanged until the arbiter takes it
	a_fill_held: assert property (@(posedge clk) disable iff (!rst_n)
		fill_valid_i && !fill_ready_o |=> fill_valid_i && $stable(fill_entry_i));

	a_rmiss_held: assert property (@(posedge clk) disable iff (!rst_n)
		rmiss_valid_i && !rmiss_ready_o |=> rmiss_valid_i && $stable(rmiss_entry_i));

endmodule

`default_nettype wire

// ==== design/fill_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module fill_fifo (
	input  wire logic                        clk,
	input  wire logic                        rst_n,

	input  wire logic                        wr_i,
	input  wire fill_types_pkg::fill_entry_t wdata_i,

	input  wire logic                        pop_i,
	output logic                             valid_o,
	output fill_types_pkg::fill_entry_t      head_o,

	input  wire fill_types_pkg::fifo_level_t afull_thresh_i,
	output fill_types_pkg::fifo_level_t      level_o,
	output logic                             afull_o
);

	import cache_cfg_pkg::*;
	import fill_types_pkg::*;

	fill_entry_t                   mem_q [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
	fifo_level_t                   level_q;
	logic                          do_pop;

	assign valid_o = (level_q != '0);
	assign do_pop  = pop_i && valid_o;  // A pop on an empty FIFO does nothing
	assign head_o  = mem_q[rd_ptr_q];   // Head shows without a read request
	assign level_o = level_q;
	assign afull_o = (level_q >= afull_thresh_i);

	always_ff @(posedge clk) begin
		if (wr_i) begin
			mem_q[wr_ptr_q] <= wdata_i;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (wr_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			level_q <= '0;
		end else begin
			case ({wr_i, do_pop})
				2'b10: begin
					level_q <= level_q + 1'b1;
				end
				2'b01: begin
					level_q <= level_q - 1'b1;
				end
				default: begin
					level_q <= level_q;  // Idle, or a write and a pop together
				end
			endcase
		end
	end

	// The arbiter only writes below the threshold, which never exceeds the depth
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		wr_i |-> (level_q < fifo_level_t'(FIFO_DEPTH)));

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop_i |-> valid_o);

endmodule

`default_nettype wire

// ==== design/fill_cfg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module fill_cfg_regs (
	input  wire logic                        clk,
	input  wire logic                        rst_n,

	input  wire fill_types_pkg::cfg_req_t    cfg_req_i,
	input  wire fill_types_pkg::fifo_level_t level_i,

	output fill_types_pkg::fifo_level_t      afull_thresh_o,
	output fill_types_pkg::fifo_level_t      cfg_rdata_o
);

	import cache_cfg_pkg::*;
	import fill_types_pkg::*;

	fifo_level_t thresh_q;
	fifo_level_t thresh_clamped;
	fifo_level_t rdata_q;

	// A zero threshold would stall the arbiter for good
	always_comb begin
		thresh_clamped = cfg_req_i.wdata;
		if (cfg_req_i.wdata == '0) begin
			thresh_clamped = fifo_level_t'(1);
		end else if (cfg_req_i.wdata > fifo_level_t'(FIFO_DEPTH)) begin
			thresh_clamped = fifo_level_t'(FIFO_DEPTH);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			thresh_q <= fifo_level_t'(AFULL_DEFAULT);
		end else if (cfg_req_i.wr_en && cfg_req_i.addr == REG_THRESH) begin
			thresh_q <= thresh_clamped;  // Writes to REG_LEVEL are dropped
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_req_i.rd_en) begin
			if (cfg_req_i.addr == REG_THRESH) begin
				rdata_q <= thresh_q;
			end else begin
				rdata_q <= level_i;
			end
		end
	end

	assign afull_thresh_o = thresh_q;
	assign cfg_rdata_o    = rdata_q;  // Held until the next read

endmodule

`default_nettype wire

// ==== design/cache_fill_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_fill_top (
	input  wire logic                        clk,
	input  wire logic                        rst_n,

	input  wire logic                        fill_valid_i,
	input  wire fill_types_pkg::fill_entry_t fill_entry_i,
	output logic                             fill_ready_o,

	input  wire logic                        rmiss_valid_i,
	input  wire fill_types_pkg::fill_entry_t rmiss_entry_i,
	output logic                             rmiss_ready_o,

	output logic                             array_valid_o,
	output fill_types_pkg::fill_entry_t      array_entry_o,
	input  wire logic                        array_pop_i,

	input  wire fill_types_pkg::cfg_req_t    cfg_req_i,
	output fill_types_pkg::fifo_level_t      cfg_rdata_o
);

	import fill_types_pkg::*;

	logic        fifo_wr;
	fill_entry_t fifo_wdata;
	logic        fifo_afull;
	fifo_level_t afull_thresh;
	fifo_level_t fifo_level;

	fill_arbiter u_arbiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.fill_valid_i  (fill_valid_i),
		.fill_entry_i  (fill_entry_i),
		.fill_ready_o  (fill_ready_o),
		.rmiss_valid_i (rmiss_valid_i),
		.rmiss_entry_i (rmiss_entry_i),
		.rmiss_ready_o (rmiss_ready_o),
		.fifo_afull_i  (fifo_afull),
		.fifo_wr_o     (fifo_wr),
		.fifo_wdata_o  (fifo_wdata)
	);

	fill_fifo u_fifo (
		.clk            (clk),
		.rst_n          (rst_n),
		.wr_i           (fifo_wr),
		.wdata_i        (fifo_wdata),
		.pop_i          (array_pop_i),
		.valid_o        (array_valid_o),
		.head_o         (array_entry_o),
		.afull_thresh_i (afull_thresh),
		.level_o        (fifo_level),
		.afull_o        (fifo_afull)
	);

	fill_cfg_regs u_cfg_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg_req_i      (cfg_req_i),
		.level_i        (fifo_level),
		.afull_thresh_o (afull_thresh),
		.cfg_rdata_o    (cfg_rdata_o)
	);

endmodule

`default_nettype wire

// ==== tests/tb_fill_checks.svh ====
task automatic check_entry(input string name, input fill_entry_t got, input fill_entry_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("** Error: %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_level(input string name, input fifo_level_t got, input fifo_level_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("** Error: %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("** Error: %s got %h expected %h", name, got, exp);
	end
endtask

task automatic timeout_fail(input string what);
	error_count++;
	$display("Timed out while waiting for %s", what);
endtask

task automatic wait_accepts(input int count, input int limit);
	int cycles;
	cycles = 0;
	while (winners.size() < count && cycles < limit) begin
		step();
		cycles++;
	end
	if (winners.size() < count) begin
		timeout_fail("accepts on the source ports");
	end
endtask

// Polls REG_LEVEL through the configuration port
task automatic wait_level(input fifo_level_t exp, input int limit);
	fifo_level_t lvl;
	int          reads;
	reads = 0;
	cfg_read(REG_LEVEL, lvl);
	while (lvl != exp && reads < limit) begin
		cfg_read(REG_LEVEL, lvl);
		reads++;
	end
	if (lvl != exp) begin
		timeout_fail("the FIFO level to reach the threshold");
	end
endtask

task automatic wait_drained(input int limit);
	int cycles;
	cycles = 0;
	while ((model_q.size() != 0 || array_valid_o) && cycles < limit) begin
		step();
		cycles++;
	end
	if (model_q.size() != 0 || array_valid_o) begin
		timeout_fail("the fill path to drain");
	end
endtask

// ==== tests/tb_cache_fill.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cache_fill;

	import cache_cfg_pkg::*;
	import fill_types_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        fill_valid_i;
	fill_entry_t fill_entry_i;
	logic        fill_ready_o;
	logic        rmiss_valid_i;
	fill_entry_t rmiss_entry_i;
	logic        rmiss_ready_o;
	logic        array_valid_o;
	fill_entry_t array_entry_o;
	logic        array_pop_i;
	cfg_req_t    cfg_req_i;
	fifo_level_t cfg_rdata_o;

	cfg_req_t    cfg_next;        // Request for the next step, cleared once driven
	fill_entry_t model_q[$];      // Entries accepted but not yet popped
	logic        winners[$];      // Accept order, high for the miss handler
	fifo_level_t thresh_m;
	fifo_level_t rd;
	logic        fill_taken;
	logic        rmiss_taken;
	logic        hold_check;      // Readies must stay low while set
	int unsigned fill_rate;
	int unsigned rmiss_rate;
	int unsigned pop_rate;
	int          check_count;
	int          error_count;
	int          test_errs;

	cache_fill_top uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.fill_valid_i  (fill_valid_i),
		.fill_entry_i  (fill_entry_i),
		.fill_ready_o  (fill_ready_o),
		.rmiss_valid_i (rmiss_valid_i),
		.rmiss_entry_i (rmiss_entry_i),
		.rmiss_ready_o (rmiss_ready_o),
		.array_valid_o (array_valid_o),
		.array_entry_o (array_entry_o),
		.array_pop_i   (array_pop_i),
		.cfg_req_i     (cfg_req_i),
		.cfg_rdata_o   (cfg_rdata_o)
	);

	always #10 clk = ~clk;

	`include "tb_fill_checks.svh"

	function automatic fill_entry_t rand_entry();
		fill_entry_t e;
		e.addr = $urandom;
		e.data = {$urandom, $urandom};
		return e;
	endfunction

	// Threshold range is 1 up to the FIFO depth
	function automatic fifo_level_t clamp_thresh(input int v);
		if (v < 1) begin
			return fifo_level_t'(1);
		end else if (v > FIFO_DEPTH) begin
			return fifo_level_t'(FIFO_DEPTH);
		end
		return fifo_level_t'(v);
	endfunction

	// Drive on the falling edge, then observe the cycle once it has settled
	task automatic step();
		@(negedge clk);
		if (fill_taken) begin
			fill_valid_i = 1'b0;
		end
		if (rmiss_taken) begin
			rmiss_valid_i = 1'b0;
		end
		if (!fill_valid_i && ($urandom % 100) < fill_rate) begin
			fill_valid_i = 1'b1;
			fill_entry_i = rand_entry();
		end
		if (!rmiss_valid_i && ($urandom % 100) < rmiss_rate) begin
			rmiss_valid_i = 1'b1;
			rmiss_entry_i = rand_entry();
		end
		array_pop_i = array_valid_o && (($urandom % 100) < pop_rate);
		cfg_req_i   = cfg_next;
		cfg_next    = '0;
		#1;
		fill_taken  = fill_valid_i && fill_ready_o;
		rmiss_taken = rmiss_valid_i && rmiss_ready_o;
		if (fill_taken) begin
			model_q.push_back(fill_entry_i);
			winners.push_back(1'b0);
		end
		if (rmiss_taken) begin
			model_q.push_back(rmiss_entry_i);
			winners.push_back(1'b1);
		end
		if (hold_check) begin
			check_bit("fill_ready_o", fill_ready_o, 1'b0);
			check_bit("rmiss_ready_o", rmiss_ready_o, 1'b0);
		end
		if (array_pop_i) begin
			if (model_q.size() == 0) begin
				error_count++;
				$display("The data array popped an entry that was never accepted");
			end else begin
				check_entry("array_entry_o", array_entry_o, model_q.pop_front());
			end
		end
	endtask

	task automatic cfg_read(input logic addr, output fifo_level_t data);
		cfg_next.rd_en = 1'b1;
		cfg_next.addr  = addr;
		step();
		step();  // Read data is registered one cycle after the strobe
		data = cfg_rdata_o;
	endtask

	task automatic cfg_write(input int v);
		cfg_next.wr_en = 1'b1;
		cfg_next.addr  = REG_THRESH;
		cfg_next.wdata = fifo_level_t'(v);
		thresh_m       = clamp_thresh(v);
		step();
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d errors", name, error_count - test_errs);
		test_errs = error_count;
	endtask

	task automatic end_run();
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(32'hb333));
		clk           = 1'b0;
		rst_n         = 1'b0;
		fill_valid_i  = 1'b0;
		fill_entry_i  = '0;
		rmiss_valid_i = 1'b0;
		rmiss_entry_i = '0;
		array_pop_i   = 1'b0;
		cfg_req_i     = '0;
		cfg_next      = '0;
		fill_taken    = 1'b0;
		rmiss_taken   = 1'b0;
		hold_check    = 1'b0;
		fill_rate     = 0;
		rmiss_rate    = 0;
		pop_rate      = 0;
		check_count   = 0;
		error_count   = 0;
		test_errs     = 0;
		thresh_m      = fifo_level_t'(AFULL_DEFAULT);
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		#1;
		check_bit("fill_ready_o", fill_ready_o, 1'b0);
		check_bit("rmiss_ready_o", rmiss_ready_o, 1'b0);
		check_bit("array_valid_o", array_valid_o, 1'b0);
		cfg_read(REG_THRESH, rd);
		check_level("REG_THRESH", rd, thresh_m);
		cfg_read(REG_LEVEL, rd);
		check_level("REG_LEVEL", rd, '0);
		end_test("reset state");

		fill_rate  = 100;  // Both sources waiting all the time
		rmiss_rate = 100;
		pop_rate   = 100;
		wait_accepts(16, 200);
		for (int i = 0; i < 16; i++) begin
			check_bit("accept source", winners[i], i[0]);
		end
		end_test("alternation");

		fill_rate  = 40;
		rmiss_rate = 40;
		pop_rate   = 50;
		repeat (3000) step();
		fill_rate  = 0;
		rmiss_rate = 0;
		pop_rate   = 100;
		wait_drained(200);
		cfg_read(REG_LEVEL, rd);
		check_level("REG_LEVEL", rd, '0);
		end_test("ordering and integrity");

		fill_rate  = 100;
		rmiss_rate = 100;
		pop_rate   = 0;
		wait_level(thresh_m, 100);
		check_level("model level", fifo_level_t'(model_q.size()), thresh_m);
		hold_check = 1'b1;
		repeat (20) step();
		hold_check = 1'b0;
		fill_rate  = 0;
		rmiss_rate = 0;
		pop_rate   = 100;
		wait_drained(200);
		end_test("back-pressure");

		cfg_write(0);
		cfg_read(REG_THRESH, rd);
		check_level("REG_THRESH", rd, thresh_m);
		cfg_write(3);
		cfg_read(REG_THRESH, rd);
		check_level("REG_THRESH", rd, thresh_m);
		fill_rate  = 100;
		rmiss_rate = 100;
		pop_rate   = 0;
		wait_level(thresh_m, 100);
		check_level("model level", fifo_level_t'(model_q.size()), thresh_m);
		cfg_write(15);
		cfg_read(REG_THRESH, rd);
		check_level("REG_THRESH", rd, thresh_m);
		wait_level(thresh_m, 100);
		check_level("model level", fifo_level_t'(model_q.size()), thresh_m);
		fill_rate  = 0;
		rmiss_rate = 0;
		pop_rate   = 100;
		wait_drained(200);
		end_test("configuration");

		end_run();
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+tests
design/cache_cfg_pkg.sv
design/fill_types_pkg.sv
design/fill_arbiter.sv
design/fill_fifo.sv
design/fill_cfg_regs.sv
design/cache_fill_top.sv
tests/tb_cache_fill.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cache_fill -f build.f
out=$(./obj_dir/Vtb_cache_fill) || true
echo "$out"
if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
